/* Bender.yml */
package:
  name: cart_bus

sources:
  - include_dirs:
      - common
    files:
      - common/gb_bus_pkg.sv
      - common/gb_loader_pkg.sv
      - hdl/gb_memmap.sv
      - hdl/mbc_chip.sv
      - loader/uart_rx.sv
      - loader/prog_loader.sv
      - hdl/cart_bus.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_cart_bus.sv

/* common/gb_bus_pkg.sv */
`default_nettype none

package gb_bus_pkg;

	// 16-bit address as issued by the CPU.
	typedef logic [15:0] cpu_adr_t;

	// Flat 21-bit address on the external memory pins.
	typedef logic [20:0] cart_adr_t;

	typedef logic [7:0] byte_t;

	// One CPU bus cycle, read and write are single-cycle strobes.
	typedef struct packed {
		cpu_adr_t adr;
		byte_t    data;
		logic     read;
		logic     write;
	} bus_req_t;

	// Bus cycle after memory map decode.
	typedef struct packed {
		bus_req_t req;
		logic     sel_bootrom;
		logic     sel_vram;
		logic     sel_ram;
		logic     sel_cart_rom;
		logic     sel_cart_ram;
	} dec_req_t;

endpackage

`default_nettype wire

/* common/gb_defs.svh */
`ifndef GB_DEFS_SVH
`define GB_DEFS_SVH

// Cartridge ROM occupies the bottom 32 KiB.
`define GB_CART_ROM_END      16'h7FFF

`define GB_VRAM_START        16'h8000
`define GB_VRAM_END          16'h9FFF

// External RAM on the cartridge.
`define GB_CART_RAM_START    16'hA000
`define GB_CART_RAM_END      16'hBFFF

// Work RAM on the board.
`define GB_WRAM_START        16'hC000
`define GB_WRAM_END          16'hDFFF

// Boot ROM overlay covers the first 256 bytes.
`define GB_BOOTROM_END       16'h00FF

// Nonzero write here unmaps the boot ROM.
`define GB_BOOT_OFF_ADR      16'hFF50

// Clocks per UART bit, small so that simulation stays short.
`define GB_UART_CLKS_PER_BIT 16

`endif

/* common/gb_loader_pkg.sv */
`default_nettype none

package gb_loader_pkg;

	import gb_bus_pkg::*;

	// Serial receiver states, one frame is 8N1.
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	// Record framing, three address bytes then one data byte.
	typedef enum logic [1:0] {
		LD_ADR_HI,
		LD_ADR_MID,
		LD_ADR_LO,
		LD_DATA
	} ld_state_e;

	// One cartridge ROM write from the loader.
	typedef struct packed {
		cart_adr_t adr;
		byte_t     data;
		logic      write;
	} ld_write_t;

endpackage

`default_nettype wire

/* files.f */
+incdir+common
common/gb_bus_pkg.sv
common/gb_loader_pkg.sv
hdl/gb_memmap.sv
hdl/mbc_chip.sv
loader/uart_rx.sv
loader/prog_loader.sv
hdl/cart_bus.sv
testbench/tb_cart_bus.sv

/* hdl/cart_bus.sv */
`timescale 1ns/1ns
`default_nettype none

module cart_bus
	import gb_bus_pkg::*;
	import gb_loader_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     prog_mode,
	input  wire logic     emu_mbc,
	input  wire bus_req_t cpu_req,
	input  wire logic     rx,
	output cart_adr_t     ext_adr,
	output byte_t         ext_data,
	output logic          n_read,
	output logic          n_write,
	output logic          n_ram_cs,
	output logic          n_cart_cs,
	output logic          n_crom_cs,
	output logic          n_cram_cs,
	output logic          n_vram_cs,
	output logic          n_bootrom_cs
);

	dec_req_t  dec;
	cart_adr_t mbc_adr;
	byte_t     mbc_data;
	logic      mbc_read;
	logic      mbc_write;
	logic      mbc_rom;
	logic      mbc_ram;
	logic      mbc_wram;
	logic      mbc_vram;
	logic      mbc_boot;
	byte_t     rx_byte;
	logic      rx_valid;
	ld_write_t ld;

	gb_memmap u_memmap (
		.clk (clk),
		.rst (rst),
		.req (cpu_req),
		.dec (dec)
	);

	mbc_chip u_mbc (
		.clk         (clk),
		.rst         (rst),
		.emu_mbc     (emu_mbc),
		.dec         (dec),
		.ext_adr     (mbc_adr),
		.ext_data    (mbc_data),
		.read        (mbc_read),
		.write       (mbc_write),
		.sel_rom     (mbc_rom),
		.sel_ram     (mbc_ram),
		.sel_wram    (mbc_wram),
		.sel_vram    (mbc_vram),
		.sel_bootrom (mbc_boot)
	);

	uart_rx u_uart_rx (
		.clk      (clk),
		.rst      (rst),
		.rx       (rx),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid)
	);

	prog_loader u_loader (
		.clk      (clk),
		.rst      (rst),
		.enable   (prog_mode),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid),
		.ld       (ld)
	);

	// Pin address and data.
	always_ff @(posedge clk) begin
		if (prog_mode) begin
			ext_adr  <= ld.adr;
			ext_data <= ld.data;
		end else begin
			ext_adr  <= mbc_adr;
			ext_data <= mbc_data;
		end
	end

	// Strobes and chip selects, all active low.
	always_ff @(posedge clk) begin
		if (rst) begin
			n_read       <= 1'b1;
			n_write      <= 1'b1;
			n_ram_cs     <= 1'b1;
			n_cart_cs    <= 1'b1;
			n_crom_cs    <= 1'b1;
			n_cram_cs    <= 1'b1;
			n_vram_cs    <= 1'b1;
			n_bootrom_cs <= 1'b1;
		end else if (prog_mode) begin
			// Loader only ever writes cartridge ROM.
			n_read       <= 1'b1;
			n_write      <= !ld.write;
			n_ram_cs     <= 1'b1;
			n_cart_cs    <= 1'b1;
			n_crom_cs    <= !ld.write;
			n_cram_cs    <= 1'b1;
			n_vram_cs    <= 1'b1;
			n_bootrom_cs <= 1'b1;
		end else begin
			n_read       <= !mbc_read;
			n_write      <= !mbc_write;
			n_ram_cs     <= !mbc_wram;
			n_cart_cs    <= !(mbc_rom || mbc_ram);
			n_crom_cs    <= !(emu_mbc && mbc_rom);
			n_cram_cs    <= !(emu_mbc && mbc_ram);
			n_vram_cs    <= !mbc_vram;
			n_bootrom_cs <= !mbc_boot;
		end
	end

endmodule

`default_nettype wire

/* hdl/gb_memmap.sv */
`timescale 1ns/1ns
`default_nettype none

`include "gb_defs.svh"

module gb_memmap
	import gb_bus_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire bus_req_t req,
	output dec_req_t      dec
);

	bus_req_t req_q;
	logic     boot_on;
	logic     access;
	logic     in_boot;

	// Request register, first pipeline stage.
	always_ff @(posedge clk) begin
		if (rst) begin
			req_q.read  <= 1'b0;
			req_q.write <= 1'b0;
		end else begin
			req_q.read  <= req.read;
			req_q.write <= req.write;
		end
		req_q.adr  <= req.adr;
		req_q.data <= req.data;
	end

	// Boot overlay stays off until the next reset.
	always_ff @(posedge clk) begin
		if (rst)
			boot_on <= 1'b1;
		else if (req_q.write && req_q.adr == `GB_BOOT_OFF_ADR && req_q.data != 8'h00)
			boot_on <= 1'b0;
	end

	assign access  = req_q.read || req_q.write;
	assign in_boot = boot_on && req_q.adr <= `GB_BOOTROM_END;

	always_comb begin
		dec              = '0;
		dec.req          = req_q;
		dec.sel_bootrom  = access && in_boot;
		// Boot ROM shadows the low end of cartridge ROM.
		dec.sel_cart_rom = access && !in_boot && req_q.adr <= `GB_CART_ROM_END;
		dec.sel_vram     = access && req_q.adr >= `GB_VRAM_START &&
		                   req_q.adr <= `GB_VRAM_END;
		dec.sel_cart_ram = access && req_q.adr >= `GB_CART_RAM_START &&
		                   req_q.adr <= `GB_CART_RAM_END;
		dec.sel_ram      = access && req_q.adr >= `GB_WRAM_START &&
		                   req_q.adr <= `GB_WRAM_END;
	end

	// Regions never overlap.
	a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({dec.sel_bootrom, dec.sel_vram, dec.sel_ram,
		          dec.sel_cart_rom, dec.sel_cart_ram}))
		else $error("gb_memmap: more than one region selected");

endmodule

`default_nettype wire

/* hdl/mbc_chip.sv */
`timescale 1ns/1ns
`default_nettype none

`include "gb_defs.svh"

module mbc_chip
	import gb_bus_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     emu_mbc,
	input  wire dec_req_t dec,
	output cart_adr_t     ext_adr,
	output byte_t         ext_data,
	output logic          read,
	output logic          write,
	output logic          sel_rom,
	output logic          sel_ram,
	output logic          sel_wram,
	output logic          sel_vram,
	output logic          sel_bootrom
);

	logic       ram_enable;
	logic [4:0] rom_bank;
	logic [1:0] upper_bank;
	logic       reg_wr;

	// Writes into the ROM area program the bank registers instead.
	assign reg_wr = emu_mbc && dec.req.write && dec.req.adr <= `GB_CART_ROM_END;

	always_ff @(posedge clk) begin
		if (rst) begin
			ram_enable <= 1'b0;
			rom_bank   <= 5'd1;
			upper_bank <= 2'd0;
		end else if (reg_wr) begin
			case (dec.req.adr[14:13])
				2'b00: ram_enable <= dec.req.data[3:0] == 4'hA;
				// Bank 0 is not selectable in the upper window.
				2'b01: rom_bank <= (dec.req.data[4:0] == 5'd0) ? 5'd1 : dec.req.data[4:0];
				2'b10: upper_bank <= dec.req.data[1:0];
				default: ;
			endcase
		end
	end

	// Address translation.
	always_comb begin
		ext_adr = cart_adr_t'(dec.req.adr);
		if (emu_mbc) begin
			if (dec.sel_cart_rom && dec.req.adr[14])
				ext_adr = {upper_bank, rom_bank, dec.req.adr[13:0]};
			else if (dec.sel_cart_ram)
				ext_adr = {6'd0, upper_bank, dec.req.adr[12:0]};
		end
	end

	assign ext_data    = dec.req.data;
	assign read        = dec.req.read;
	assign write       = dec.req.write && !reg_wr;
	assign sel_rom     = dec.sel_cart_rom && !reg_wr;
	// Without emulation the cartridge gates its own RAM.
	assign sel_ram     = dec.sel_cart_ram && (ram_enable || !emu_mbc);
	assign sel_wram    = dec.sel_ram;
	assign sel_vram    = dec.sel_vram;
	assign sel_bootrom = dec.sel_bootrom;

	a_rom_ram_excl: assert property (@(posedge clk) disable iff (rst)
		!(sel_rom && sel_ram))
		else $error("mbc_chip: ROM and RAM selected together");

endmodule

`default_nettype wire

/* loader/prog_loader.sv */
`timescale 1ns/1ns
`default_nettype none

module prog_loader
	import gb_bus_pkg::*;
	import gb_loader_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst,
	input  wire logic  enable,
	input  wire byte_t rx_byte,
	input  wire logic  rx_valid,
	output ld_write_t  ld
);

	ld_state_e state;
	cart_adr_t adr_q;
	byte_t     data_q;
	logic      write_q;

	// Record framing.
	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= LD_ADR_HI;
			write_q <= 1'b0;
		end else begin
			write_q <= 1'b0;
			if (!enable)
				state <= LD_ADR_HI;
			else if (rx_valid) begin
				case (state)
					LD_ADR_HI:  state <= LD_ADR_MID;
					LD_ADR_MID: state <= LD_ADR_LO;
					LD_ADR_LO:  state <= LD_DATA;
					LD_DATA: begin
						write_q <= 1'b1;
						state   <= LD_ADR_HI;
					end
					default: state <= LD_ADR_HI;
				endcase
			end
		end
	end

	// Address comes MSB first.
	always_ff @(posedge clk) begin
		if (enable && rx_valid) begin
			case (state)
				// Only 21 address bits exist.
				LD_ADR_HI:  adr_q[20:16] <= rx_byte[4:0];
				LD_ADR_MID: adr_q[15:8]  <= rx_byte;
				LD_ADR_LO:  adr_q[7:0]   <= rx_byte;
				LD_DATA:    data_q       <= rx_byte;
				default: ;
			endcase
		end
	end

	assign ld = '{adr: adr_q, data: data_q, write: write_q};

	a_no_write_disabled: assert property (@(posedge clk) disable iff (rst)
		!enable |=> !ld.write)
		else $error("prog_loader: write issued outside program mode");

endmodule

`default_nettype wire

/* loader/uart_rx.sv */
`timescale 1ns/1ns
`default_nettype none

`include "gb_defs.svh"

module uart_rx
	import gb_bus_pkg::*;
	import gb_loader_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic rx,
	output byte_t     rx_byte,
	output logic      rx_valid
);

	localparam int CLKS_PER_BIT = `GB_UART_CLKS_PER_BIT;
	localparam int CNT_W        = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLKS_PER_BIT / 2 - 1);

	logic [1:0]       rx_sync;
	logic             rx_s;
	rx_state_e        state;
	logic [CNT_W-1:0] cnt;
	logic [2:0]       bit_idx;
	byte_t            shreg;

	// Line idles high.
	always_ff @(posedge clk) begin
		if (rst)
			rx_sync <= 2'b11;
		else
			rx_sync <= {rx_sync[0], rx};
	end

	assign rx_s = rx_sync[1];

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= RX_IDLE;
			cnt      <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					cnt <= '0;
					if (!rx_s)
						state <= RX_START;
				end
				RX_START: begin
					// Recheck at mid start bit to reject glitches.
					if (cnt == HALF_CNT) begin
						cnt     <= '0;
						bit_idx <= '0;
						state   <= rx_s ? RX_IDLE : RX_DATA;
					end else
						cnt <= cnt + 1'b1;
				end
				RX_DATA: begin
					if (cnt == LAST_CNT) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end else
						cnt <= cnt + 1'b1;
				end
				RX_STOP: begin
					if (cnt == LAST_CNT) begin
						// Framing error drops the byte.
						rx_valid <= rx_s;
						state    <= RX_IDLE;
					end else
						cnt <= cnt + 1'b1;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// LSB arrives first.
	always_ff @(posedge clk) begin
		if (state == RX_DATA && cnt == LAST_CNT)
			shreg <= {rx_s, shreg[7:1]};
	end

	assign rx_byte = shreg;

endmodule

`default_nettype wire

/* testbench/tb_cart_bus.sv */
`timescale 1ns/1ns
`default_nettype none

`include "gb_defs.svh"

module tb_cart_bus
	import gb_bus_pkg::*;
();

	localparam int BIT_CLKS = `GB_UART_CLKS_PER_BIT;

	// Pin order is n_read, n_write, n_ram_cs, n_cart_cs, n_crom_cs, n_cram_cs, n_vram_cs, n_bootrom_cs.
	localparam logic [7:0] PINS_IDLE = 8'hFF;
	// Loader write pulls n_write and n_crom_cs low.
	localparam logic [7:0] PINS_LOAD = 8'b1011_0111;

	// Pin snapshot expected at a given cycle.
	typedef struct packed {
		logic [31:0] due;
		cart_adr_t   adr;
		byte_t       data;
		logic [7:0]  pins;
	} exp_t;

	// One write seen on the pins.
	typedef struct packed {
		cart_adr_t  adr;
		byte_t      data;
		logic [7:0] pins;
	} wr_t;

	logic      clk = 1'b0;
	logic      rst;
	logic      prog_mode;
	logic      emu_mbc;
	bus_req_t  cpu_req;
	logic      rx;
	cart_adr_t ext_adr;
	byte_t     ext_data;
	logic      n_read;
	logic      n_write;
	logic      n_ram_cs;
	logic      n_cart_cs;
	logic      n_crom_cs;
	logic      n_cram_cs;
	logic      n_vram_cs;
	logic      n_bootrom_cs;

	integer      seed = 32'hb2b15f6f;
	logic [31:0] cycle = 0;
	int          errors = 0;
	string       test_name = "reset";
	exp_t        exp_q[$];
	wr_t         wr_q[$];

	// Reference model state.
	logic       m_boot_on;
	logic       m_ram_en;
	logic [4:0] m_rom_bank;
	logic [1:0] m_upper;

	cart_bus u_dut (
		.clk          (clk),
		.rst          (rst),
		.prog_mode    (prog_mode),
		.emu_mbc      (emu_mbc),
		.cpu_req      (cpu_req),
		.rx           (rx),
		.ext_adr      (ext_adr),
		.ext_data     (ext_data),
		.n_read       (n_read),
		.n_write      (n_write),
		.n_ram_cs     (n_ram_cs),
		.n_cart_cs    (n_cart_cs),
		.n_crom_cs    (n_crom_cs),
		.n_cram_cs    (n_cram_cs),
		.n_vram_cs    (n_vram_cs),
		.n_bootrom_cs (n_bootrom_cs)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	function automatic logic [7:0] pins_now();
		return {n_read, n_write, n_ram_cs, n_cart_cs,
		        n_crom_cs, n_cram_cs, n_vram_cs, n_bootrom_cs};
	endfunction

	function automatic cpu_adr_t rand_adr(input cpu_adr_t base, input cpu_adr_t mask);
		return base | (cpu_adr_t'($random(seed)) & mask);
	endfunction

	// Expected pins for one CPU cycle, then the model state update.
	function automatic exp_t ref_map(input bus_req_t r, input logic emu);
		exp_t e;
		logic access;
		logic boot;
		logic sel_boot;
		logic sel_rom;
		logic sel_vram;
		logic sel_cram;
		logic sel_wram;
		logic reg_wr;
		logic crom;
		logic cram;
		access   = r.read || r.write;
		boot     = m_boot_on && r.adr <= `GB_BOOTROM_END;
		sel_boot = access && boot;
		sel_rom  = access && !boot && r.adr <= `GB_CART_ROM_END;
		sel_vram = access && r.adr >= `GB_VRAM_START && r.adr <= `GB_VRAM_END;
		sel_cram = access && r.adr >= `GB_CART_RAM_START && r.adr <= `GB_CART_RAM_END;
		sel_wram = access && r.adr >= `GB_WRAM_START && r.adr <= `GB_WRAM_END;
		reg_wr   = emu && r.write && r.adr <= `GB_CART_ROM_END;
		crom     = sel_rom && !reg_wr;
		cram     = sel_cram && (m_ram_en || !emu);

		e      = '0;
		e.due  = cycle + 2;
		e.data = r.data;
		e.adr  = cart_adr_t'(r.adr);
		if (emu && sel_rom && r.adr >= 16'h4000)
			e.adr = cart_adr_t'({m_upper, m_rom_bank}) * 21'h4000 + cart_adr_t'(r.adr[13:0]);
		else if (emu && sel_cram)
			e.adr = cart_adr_t'(m_upper) * 21'h2000 + cart_adr_t'(r.adr[12:0]);
		e.pins = {!r.read, !(r.write && !reg_wr), !sel_wram, !(crom || cram),
		          !(emu && crom), !(emu && cram), !sel_vram, !sel_boot};

		if (r.write && r.adr == `GB_BOOT_OFF_ADR && r.data != 8'h00)
			m_boot_on = 1'b0;
		if (reg_wr) begin
			if (r.adr <= 16'h1FFF)
				m_ram_en = (r.data[3:0] == 4'hA);
			else if (r.adr <= 16'h3FFF)
				m_rom_bank = (r.data[4:0] == 5'd0) ? 5'd1 : r.data[4:0];
			else if (r.adr <= 16'h5FFF)
				m_upper = r.data[1:0];
		end
		return e;
	endfunction

	task automatic stop_on_error();
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check(input string what, input logic [31:0] expected,
	                     input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s, %s: expected 0x%0h, actual 0x%0h",
			         test_name, what, expected, actual);
			stop_on_error();
		end
	endtask

	task automatic drive_req(input cpu_adr_t adr, input byte_t data, input logic rd,
	                         input logic wr);
		@(negedge clk);
		cpu_req = bus_req_t'({adr, data, rd, wr});
	endtask

	task automatic bus_cycle(input cpu_adr_t adr, input byte_t data, input logic rd,
	                         input logic wr);
		drive_req(adr, data, rd, wr);
		exp_q.push_back(ref_map(cpu_req, emu_mbc));
	endtask

	// Idle the bus and wait until every expected result was compared.
	task automatic drain();
		int n = 0;
		@(negedge clk);
		cpu_req = '0;
		while (exp_q.size() != 0 && n < 8) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout: %0d CPU results never reached the pins in test %s",
			         exp_q.size(), test_name);
			stop_on_error();
		end
	endtask

	// 8N1 frame, stop bit value given so that framing errors can be sent.
	task automatic uart_send(input byte_t b, input logic stop);
		logic [9:0] frame;
		frame = {stop, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			rx = frame[i];
			repeat (BIT_CLKS - 1) @(negedge clk);
		end
		@(negedge clk);
		rx = 1'b1;
	endtask

	task automatic wait_write();
		int n = 0;
		while (wr_q.size() == 0 && n < 4 * BIT_CLKS) begin
			@(negedge clk);
			n++;
		end
		if (wr_q.size() == 0) begin
			$display("Timeout: no cartridge ROM write appeared on the pins in test %s",
			         test_name);
			stop_on_error();
		end
	endtask

	task automatic load_record(input cart_adr_t adr, input byte_t data);
		byte_t hi;
		wr_t   w;
		// Top three bits of the first byte are don't care.
		hi = {3'($random(seed)), adr[20:16]};
		uart_send(hi, 1'b1);
		uart_send(adr[15:8], 1'b1);
		uart_send(adr[7:0], 1'b1);
		uart_send(data, 1'b1);
		wait_write();
		w = wr_q.pop_front();
		check("loader address", 32'(adr), 32'(w.adr));
		check("loader data", 32'(data), 32'(w.data));
		check("loader strobes", 32'(PINS_LOAD), 32'(w.pins));
		repeat (2) @(negedge clk);
		check("extra loader writes", 0, wr_q.size());
	endtask

	// CPU reads during program mode must leave the pins idle.
	task automatic cpu_blocked(input int n);
		for (int i = 0; i < n; i++) begin
			drive_req(cpu_adr_t'($random(seed)), 8'h00, 1'b1, 1'b0);
			check("pins in program mode", 32'(PINS_IDLE), 32'(pins_now()));
		end
		@(negedge clk);
		cpu_req = '0;
		repeat (3) begin
			@(negedge clk);
			check("pins in program mode", 32'(PINS_IDLE), 32'(pins_now()));
		end
	endtask

	// Compare pins against the oldest due expectation.
	always @(negedge clk) begin : compare
		exp_t e;
		while (exp_q.size() != 0 && exp_q[0].due == cycle) begin
			e = exp_q.pop_front();
			check("address", 32'(e.adr), 32'(ext_adr));
			check("data", 32'(e.data), 32'(ext_data));
			check("strobes and selects", 32'(e.pins), 32'(pins_now()));
		end
	end

	// Record every write strobe seen on the pins.
	always @(negedge clk) begin
		if (!rst && !n_write)
			wr_q.push_back({ext_adr, ext_data, pins_now()});
	end

	initial begin
		byte_t     bank;
		cart_adr_t ld_adr;
		rst        = 1'b1;
		prog_mode  = 1'b0;
		emu_mbc    = 1'b1;
		cpu_req    = '0;
		rx         = 1'b1;
		m_boot_on  = 1'b1;
		m_ram_en   = 1'b0;
		m_rom_bank = 5'd1;
		m_upper    = 2'd0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check("pins after reset", 32'(PINS_IDLE), 32'(pins_now()));

		test_name = "boot overlay";
		bus_cycle(16'h0010, 8'h00, 1'b1, 1'b0);
		bus_cycle(`GB_BOOT_OFF_ADR, 8'h01, 1'b0, 1'b1);
		bus_cycle(16'h0010, 8'h00, 1'b1, 1'b0);
		drain();

		test_name = "region decode";
		repeat (200)
			bus_cycle(cpu_adr_t'($random(seed)), byte_t'($random(seed)), 1'b1, 1'b0);
		drain();

		test_name = "mbc banking";
		for (int i = 0; i < 40; i++) begin
			bank = (i % 5 == 0) ? 8'h00 : byte_t'($random(seed));
			bus_cycle(rand_adr(16'h2000, 16'h1FFF), bank, 1'b0, 1'b1);
			bus_cycle(rand_adr(16'h4000, 16'h1FFF), byte_t'($random(seed)), 1'b0, 1'b1);
			bus_cycle(rand_adr(16'h0000, 16'h3FFF), 8'h00, 1'b1, 1'b0);
			repeat (4)
				bus_cycle(rand_adr(16'h4000, 16'h3FFF), 8'h00, 1'b1, 1'b0);
		end
		drain();

		test_name = "cart ram gating";
		repeat (8)
			bus_cycle(rand_adr(16'hA000, 16'h1FFF), 8'h00, 1'b1, 1'b0);
		bus_cycle(rand_adr(16'h0000, 16'h1FFF), 8'h0A, 1'b0, 1'b1);
		repeat (8)
			bus_cycle(rand_adr(16'hA000, 16'h1FFF), 8'h00, 1'b1, 1'b0);
		bus_cycle(rand_adr(16'h0000, 16'h1FFF), 8'h00, 1'b0, 1'b1);
		repeat (8)
			bus_cycle(rand_adr(16'hA000, 16'h1FFF), 8'h00, 1'b1, 1'b0);
		drain();

		test_name = "no bank emulation";
		emu_mbc = 1'b0;
		repeat (16)
			bus_cycle(rand_adr(16'hA000, 16'h1FFF), 8'h00, 1'b1, 1'b0);
		repeat (4)
			bus_cycle(rand_adr(16'h0000, 16'h7FFF), byte_t'($random(seed)), 1'b0, 1'b1);
		repeat (16)
			bus_cycle(cpu_adr_t'($random(seed)), 8'h00, 1'b1, 1'b0);
		drain();
		emu_mbc = 1'b1;

		test_name = "program loader";
		prog_mode = 1'b1;
		repeat (2) @(negedge clk);
		wr_q.delete();
		for (int i = 0; i < 6; i++) begin
			ld_adr = cart_adr_t'($random(seed));
			load_record(ld_adr, byte_t'($random(seed)));
			cpu_blocked(6);
		end

		test_name = "bad stop bit";
		uart_send(8'h01, 1'b1);
		uart_send(8'h23, 1'b1);
		uart_send(8'h45, 1'b1);
		uart_send(8'h67, 1'b0);
		repeat (3 * BIT_CLKS) @(negedge clk);
		check("writes after bad frame", 0, wr_q.size());
		// Leaving program mode restarts record framing.
		prog_mode = 1'b0;
		repeat (2) @(negedge clk);
		prog_mode = 1'b1;

		test_name = "program loader resync";
		load_record(21'h1ABCDE, 8'h5A);
		prog_mode = 1'b0;
		repeat (2) @(negedge clk);

		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
